// ==== Bender.yml ====
package:
  name: back_end

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/backEndPkg.sv
      - common/laneIf.sv
      - common/pipeCtlIf.sv
      - verilog/pipeControl.sv
      - verilog/executeToMemoryRegister.sv
      - memory/dataMemory.sv
      - verilog/writebackStage.sv
      - verilog/backEndTop.sv
  - target: test
    files:
      - tb/tbClock.sv
      - tb/backEndTb.sv

// ==== common/backEndPkg.sv ====
`default_nettype none

`include "backEnd_config.svh"

package backEndPkg;

    // Data or address word.
    typedef logic [`BE_XLEN-1:0] word_t;

    // Register file index.
    typedef logic [$clog2(`BE_NUM_REGS)-1:0] regAddr_t;

    // Access size in bits [1:0], unsigned load in bit 2.
    typedef logic [2:0] addrCtl_t;

    typedef enum logic [1:0] {
        resAlu = 2'b00,
        resMem = 2'b01,
        resPc4 = 2'b10,
        resPc8 = 2'b11
    } resultSrc_e;

    typedef enum logic {
        ctlRun  = 1'b0,
        ctlHold = 1'b1 // Memory stage holds a pair that already passed.
    } ctlState_e;

endpackage

`default_nettype wire

// ==== common/backEnd_config.svh ====
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// Data path width in bits.
`define BE_XLEN 32

// Architectural register count, x0 included.
`define BE_NUM_REGS 32

// Data memory depth in 32-bit words.
`define BE_MEM_WORDS 256

`endif

// ==== common/laneIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface laneIf;

    logic                   regWrite;
    backEndPkg::resultSrc_e resultSrc;
    logic                   memWrite;
    backEndPkg::addrCtl_t   addrCtl;
    backEndPkg::word_t      aluResult; // Also the memory address.
    backEndPkg::word_t      writeData;
    backEndPkg::regAddr_t   rd;
    backEndPkg::word_t      pcPlus4;
    backEndPkg::word_t      pcPlus8;

    modport source (
        output regWrite, resultSrc, memWrite, addrCtl,
        output aluResult, writeData, rd, pcPlus4, pcPlus8
    );

    modport sink (
        input regWrite, resultSrc, memWrite, addrCtl,
        input aluResult, writeData, rd, pcPlus4, pcPlus8
    );

endinterface

`default_nettype wire

// ==== common/pipeCtlIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface pipeCtlIf;

    logic en1;
    logic en2;
    logic clear1; // Turns lane 1 into a bubble.
    logic clear2;

    modport ctl (
        output en1, en2, clear1, clear2
    );

    modport stage (
        input en1, en2, clear1, clear2
    );

endinterface

`default_nettype wire

// ==== memory/dataMemory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "backEnd_config.svh"

module dataMemory (
    input  wire logic         clk,
    input  wire logic         storeGate,
    laneIf.sink               lane1,
    laneIf.sink               lane2,
    output backEndPkg::word_t loadData1,
    output backEndPkg::word_t loadData2
);

    localparam int AddrBits = $clog2(`BE_MEM_WORDS);

    backEndPkg::word_t mem [`BE_MEM_WORDS];

    logic [AddrBits-1:0] wordAddr1;
    logic [AddrBits-1:0] wordAddr2;
    logic [1:0]          off1;
    logic [1:0]          off2;
    logic [3:0]          we1;
    logic [3:0]          we2;
    backEndPkg::word_t   data1;
    backEndPkg::word_t   data2;
    backEndPkg::word_t   merged2;

    function automatic logic [3:0] byteMask(input backEndPkg::addrCtl_t ctlCode,
                                            input logic [1:0] off);
        logic [3:0] mask;
        case (ctlCode[1:0])
            2'b00:   mask = 4'b0001 << off;
            2'b01:   mask = 4'b0011 << {off[1], 1'b0};
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    // Replicate the store data so every lane of the word sees it.
    function automatic backEndPkg::word_t alignStore(input backEndPkg::addrCtl_t ctlCode,
                                                     input backEndPkg::word_t data);
        case (ctlCode[1:0])
            2'b00:   return {4{data[7:0]}};
            2'b01:   return {2{data[15:0]}};
            default: return data;
        endcase
    endfunction

    function automatic backEndPkg::word_t extendLoad(input backEndPkg::addrCtl_t ctlCode,
                                                     input backEndPkg::word_t raw,
                                                     input logic [1:0] off);
        logic [7:0]  loadByte;
        logic [15:0] loadHalf;
        loadByte = raw[8*off +: 8];
        loadHalf = raw[16*off[1] +: 16];
        case (ctlCode[1:0])
            2'b00: begin
                return ctlCode[2] ? {{(`BE_XLEN-8){1'b0}}, loadByte}
                                  : {{(`BE_XLEN-8){loadByte[7]}}, loadByte};
            end
            2'b01: begin
                return ctlCode[2] ? {{(`BE_XLEN-16){1'b0}}, loadHalf}
                                  : {{(`BE_XLEN-16){loadHalf[15]}}, loadHalf};
            end
            default: return raw;
        endcase
    endfunction

    assign wordAddr1 = lane1.aluResult[AddrBits+1:2];
    assign wordAddr2 = lane2.aluResult[AddrBits+1:2];
    assign off1      = lane1.aluResult[1:0];
    assign off2      = lane2.aluResult[1:0];

    assign we1   = lane1.memWrite ? byteMask(lane1.addrCtl, off1) : 4'b0000;
    assign we2   = lane2.memWrite ? byteMask(lane2.addrCtl, off2) : 4'b0000;
    assign data1 = alignStore(lane1.addrCtl, lane1.writeData);
    assign data2 = alignStore(lane2.addrCtl, lane2.writeData);

    // Lane 2 is younger and must see lane 1's store from the same pair.
    always_comb begin
        merged2 = mem[wordAddr2];
        for (int b = 0; b < 4; b++) begin
            if (we1[b] && (wordAddr1 == wordAddr2)) merged2[8*b +: 8] = data1[8*b +: 8];
        end
    end

    assign loadData1 = extendLoad(lane1.addrCtl, mem[wordAddr1], off1);
    assign loadData2 = extendLoad(lane2.addrCtl, merged2, off2);

    always_ff @(posedge clk) begin
        if (storeGate) begin
            for (int b = 0; b < 4; b++) begin
                if (we1[b]) mem[wordAddr1][8*b +: 8] <= data1[8*b +: 8];
                if (we2[b]) mem[wordAddr2][8*b +: 8] <= data2[8*b +: 8]; // Lane 2 wins.
            end
        end
    end

    legalStore1: assert property (
        @(posedge clk) lane1.memWrite |-> (lane1.addrCtl inside {3'b000, 3'b001, 3'b010})
    ) else $error("Illegal store code on lane 1.");

    legalStore2: assert property (
        @(posedge clk) lane2.memWrite |-> (lane2.addrCtl inside {3'b000, 3'b001, 3'b010})
    ) else $error("Illegal store code on lane 2.");

endmodule

`default_nettype wire

// ==== tb/backEndTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module backEndTb;

    localparam int MaxCmds = 96;

    logic        clk;
    logic        rst1;
    logic        stall, flush1, flush2;
    logic        regWrite1, memWrite1, regWrite2, memWrite2;
    logic [1:0]  resultSrc1, resultSrc2;
    logic [2:0]  addrCtl1, addrCtl2;
    logic [31:0] aluResult1, writeData1, pcPlus4_1, pcPlus8_1;
    logic [31:0] aluResult2, writeData2, pcPlus4_2, pcPlus8_2;
    logic [4:0]  rd1, rd2, readAddr1, readAddr2;
    logic [31:0] readData1, readData2;
    logic        wbWrite1, wbWrite2;
    logic [4:0]  wbRd1, wbRd2;
    logic [31:0] wbResult1, wbResult2;

    // Parsed stimulus commands.
    logic [7:0]  cmdOp    [MaxCmds];
    logic [31:0] cmdField [MaxCmds][14];
    int          numCmds;
    int          totalCycles;
    int          cycleLimit;
    int          cycleCount;

    logic [31:0] lastPcBase; // PC+4 of lane 1 in the last pair.
    logic        pendingFlush1, pendingFlush2;
    logic [31:0] writeCount [32];
    logic [31:0] lastResult [32]; // Last value seen on the writeback port per register.

    tbClock #(.PeriodNs(8)) clockGen (.clk(clk));

    backEndTop UUT (
        .clk(clk), .rst1(rst1), .stall(stall), .flush1(flush1), .flush2(flush2),
        .regWrite1(regWrite1), .resultSrc1(resultSrc1), .memWrite1(memWrite1),
        .addrCtl1(addrCtl1), .aluResult1(aluResult1), .writeData1(writeData1),
        .rd1(rd1), .pcPlus4_1(pcPlus4_1), .pcPlus8_1(pcPlus8_1),
        .regWrite2(regWrite2), .resultSrc2(resultSrc2), .memWrite2(memWrite2),
        .addrCtl2(addrCtl2), .aluResult2(aluResult2), .writeData2(writeData2),
        .rd2(rd2), .pcPlus4_2(pcPlus4_2), .pcPlus8_2(pcPlus8_2),
        .readAddr1(readAddr1), .readAddr2(readAddr2),
        .readData1(readData1), .readData2(readData2),
        .wbWrite1(wbWrite1), .wbWrite2(wbWrite2), .wbRd1(wbRd1), .wbRd2(wbRd2),
        .wbResult1(wbResult1), .wbResult2(wbResult2)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic loadCommands();
        int         fd;
        int         code;
        int         want;
        int         ch;
        logic [7:0] op;
        numCmds     = 0;
        totalCycles = 4; // Final drain.
        fd = $fopen("tb/backEnd_stimulus.txt", "r");
        if (fd == 0) abortRun("cannot open the stimulus file tb/backEnd_stimulus.txt");
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) ch = $fgetc(fd);
            end else begin
                if (numCmds >= MaxCmds) abortRun("the stimulus file holds too many commands");
                cmdOp[numCmds] = op;
                case (op)
                    "P": begin
                        want = 14;
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            cmdField[numCmds][0], cmdField[numCmds][1], cmdField[numCmds][2],
                            cmdField[numCmds][3], cmdField[numCmds][4], cmdField[numCmds][5],
                            cmdField[numCmds][6], cmdField[numCmds][7], cmdField[numCmds][8],
                            cmdField[numCmds][9], cmdField[numCmds][10], cmdField[numCmds][11],
                            cmdField[numCmds][12], cmdField[numCmds][13]);
                        totalCycles += 1;
                    end
                    "S": begin
                        want = 1;
                        code = $fscanf(fd, "%h", cmdField[numCmds][0]);
                        if (cmdField[numCmds][0] == 0) abortRun("a stall needs at least one cycle");
                        totalCycles += cmdField[numCmds][0] + 1;
                    end
                    "F": begin
                        want = 1;
                        code = $fscanf(fd, "%h", cmdField[numCmds][0]);
                    end
                    "C": begin
                        want = 3;
                        code = $fscanf(fd, "%h %h %h", cmdField[numCmds][0],
                                       cmdField[numCmds][1], cmdField[numCmds][2]);
                        totalCycles += 3;
                    end
                    default: abortRun($sformatf("unknown stimulus command %c", op));
                endcase
                if (code != want) abortRun($sformatf("stimulus command %0d is malformed", numCmds));
                numCmds++;
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
        if (numCmds == 0) abortRun("the stimulus file holds no commands");
        cycleLimit = 4 * totalCycles + 16;
    endtask

    task automatic insertBubble();
        {regWrite1, resultSrc1, memWrite1, addrCtl1, rd1} <= '0;
        {regWrite2, resultSrc2, memWrite2, addrCtl2, rd2} <= '0;
        {aluResult1, writeData1, pcPlus4_1, pcPlus8_1} <= '0;
        {aluResult2, writeData2, pcPlus4_2, pcPlus8_2} <= '0;
        flush1 <= 1'b0;
        flush2 <= 1'b0;
    endtask

    task automatic drivePair(input int idx);
        logic [31:0] base;
        base       = $urandom & 32'hffff_fffc;
        lastPcBase = base;
        regWrite1  <= cmdField[idx][0][0];
        resultSrc1 <= cmdField[idx][1][1:0];
        memWrite1  <= cmdField[idx][2][0];
        addrCtl1   <= cmdField[idx][3][2:0];
        aluResult1 <= cmdField[idx][4];
        writeData1 <= cmdField[idx][5];
        rd1        <= cmdField[idx][6][4:0];
        regWrite2  <= cmdField[idx][7][0];
        resultSrc2 <= cmdField[idx][8][1:0];
        memWrite2  <= cmdField[idx][9][0];
        addrCtl2   <= cmdField[idx][10][2:0];
        aluResult2 <= cmdField[idx][11];
        writeData2 <= cmdField[idx][12];
        rd2        <= cmdField[idx][13][4:0];
        // Lane 2 is the next instruction, four bytes on.
        pcPlus4_1  <= base;
        pcPlus8_1  <= base + 32'd4;
        pcPlus4_2  <= base + 32'd4;
        pcPlus8_2  <= base + 32'd8;
        flush1     <= pendingFlush1;
        flush2     <= pendingFlush2;
        pendingFlush1 = 1'b0;
        pendingFlush2 = 1'b0;
    endtask

    task automatic runCheck(input int idx);
        string       name;
        logic [4:0]  regIdx;
        logic [31:0] expected;
        regIdx = cmdField[idx][0][4:0];
        name   = $sformatf("check %0d x%0d", idx, regIdx);
        @(posedge clk);
        insertBubble();
        readAddr1 <= regIdx;
        readAddr2 <= regIdx;
        repeat (2) @(posedge clk); // Capture, then register file write.
        @(negedge clk);
        case (cmdField[idx][1])
            0, 1: begin
                expected = cmdField[idx][2];
                if (cmdField[idx][1] == 1) expected = lastPcBase + expected;
                checkEqual({name, " port 1"}, expected, readData1);
                checkEqual({name, " port 2"}, expected, readData2);
                if (regIdx != 0) checkEqual({name, " writeback"}, expected, lastResult[regIdx]);
            end
            2: checkEqual({name, " writes"}, cmdField[idx][2], writeCount[regIdx]);
            default: abortRun($sformatf("check command %0d has an unknown mode", idx));
        endcase
    endtask

    task automatic runCommands();
        int idx;
        idx = 0;
        while (idx < numCmds) begin
            case (cmdOp[idx])
                "P": begin
                    @(posedge clk);
                    drivePair(idx);
                end
                "S": begin
                    if (idx + 1 >= numCmds || cmdOp[idx + 1] != "P") begin
                        abortRun("a stall command must be followed by a pair");
                    end
                    @(posedge clk);
                    stall <= 1'b1;
                    drivePair(idx + 1); // Held at the input for the whole stall.
                    repeat (cmdField[idx][0] - 1) @(posedge clk);
                    @(posedge clk);
                    stall <= 1'b0;
                    idx++;
                end
                "F": begin
                    if (cmdField[idx][0] == 1) pendingFlush1 = 1'b1;
                    else pendingFlush2 = 1'b1;
                end
                default: runCheck(idx);
            endcase
            idx++;
        end
    endtask

    // Writeback pulses per register, taken from the cycle before each edge.
    always @(posedge clk) begin
        if (rst1 === 1'b0) begin
            if (wbWrite1 === 1'b1) begin
                writeCount[wbRd1] = writeCount[wbRd1] + 1;
                lastResult[wbRd1] = wbResult1;
            end
            if (wbWrite2 === 1'b1) begin
                writeCount[wbRd2] = writeCount[wbRd2] + 1;
                lastResult[wbRd2] = wbResult2; // Younger lane wins.
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            abortRun($sformatf("timeout, the run passed its limit of %0d cycles", cycleLimit));
        end
    end

    initial begin
        void'($urandom(86));
        for (int r = 0; r < 32; r++) begin
            writeCount[r] = '0;
            lastResult[r] = '0;
        end
        pendingFlush1 = 1'b0;
        pendingFlush2 = 1'b0;
        lastPcBase    = '0;
        rst1   = 1'b1;
        stall  = 1'b0;
        flush1 = 1'b0;
        flush2 = 1'b0;
        {regWrite1, resultSrc1, memWrite1, addrCtl1, rd1} = '0;
        {regWrite2, resultSrc2, memWrite2, addrCtl2, rd2} = '0;
        {aluResult1, writeData1, pcPlus4_1, pcPlus8_1} = '0;
        {aluResult2, writeData2, pcPlus4_2, pcPlus8_2} = '0;
        readAddr1 = '0;
        readAddr2 = '0;
        loadCommands();
        repeat (16) @(posedge clk);
        rst1 <= 1'b0;
        runCommands();
        @(posedge clk);
        insertBubble();
        repeat (3) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/backEnd_stimulus.txt ====
# P regWrite resultSrc memWrite addrCtl aluResult writeData rd, lane 1 then lane 2; all hex
# S cycles (next P is held at the input) | F lane | C reg mode value (0 value, 1 PC base+value, 2 writes)
P 1 0 0 0 00001234 00000000 01  1 2 0 0 00000000 00000000 02
C 01 0 00001234
C 02 1 00000004
P 1 3 0 0 00000000 00000000 03  1 0 0 0 deadbeef 00000000 00
C 03 1 00000004
C 00 0 00000000
P 1 2 0 0 00000000 00000000 04  1 3 0 0 00000000 00000000 05
C 04 1 00000000
C 05 1 00000008
# Every load and store size.
P 0 0 1 2 00000040 8899aabb 00  0 0 1 2 00000044 7f8001fe 00
P 1 1 0 0 00000041 00000000 06  1 1 0 4 00000042 00000000 07
P 1 1 0 1 00000042 00000000 08  1 1 0 5 00000040 00000000 09
P 0 0 1 0 00000045 12345655 00  0 0 1 1 00000046 0000c3c3 00
P 1 1 0 2 00000044 00000000 0a  1 1 0 0 00000044 00000000 0b
C 06 0 ffffffaa
C 07 0 00000099
C 08 0 ffff8899
C 09 0 0000aabb
C 0a 0 c3c355fe
C 0b 0 fffffffe
# Store forwarding inside a pair, then lane 2 priority on one register.
P 0 0 1 2 00000080 11111111 00  0 0 0 0 00000000 00000000 00
P 0 0 1 0 00000082 000000ab 00  1 1 0 2 00000080 00000000 0c
P 1 0 0 0 0000aaaa 00000000 0d  1 0 0 0 0000bbbb 00000000 0d
C 0c 0 11ab1111
C 0d 0 0000bbbb
# Flushes.
P 1 0 0 0 00000e0e 00000000 0e  0 0 1 2 00000088 01020304 00
F 1
P 1 0 0 0 ffffffff 00000000 0e  1 0 0 0 00005a5a 00000000 0f
F 2
P 1 0 0 0 00001616 00000000 10  0 0 1 2 00000088 deadbeef 00
P 1 1 0 2 00000088 00000000 11  0 0 0 0 00000000 00000000 00
C 0e 0 00000e0e
C 0f 0 00005a5a
C 10 0 00001616
C 11 0 01020304
# Stall over a store and load pair.
P 0 0 1 2 00000090 00000001 00  1 1 0 2 00000090 00000000 14
S 4
P 0 0 1 1 00000092 00000002 00  1 1 0 2 00000090 00000000 15
P 1 1 0 2 00000090 00000000 16  1 1 0 5 00000092 00000000 17
C 14 0 00000001
C 15 0 00020001
C 16 0 00020001
C 17 0 00000002
C 14 2 00000001
C 15 2 00000001

// ==== tb/tbClock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PeriodNs / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/backEndPkg.sv
common/laneIf.sv
common/pipeCtlIf.sv
verilog/pipeControl.sv
verilog/executeToMemoryRegister.sv
memory/dataMemory.sv
verilog/writebackStage.sv
verilog/backEndTop.sv
tb/tbClock.sv
tb/backEndTb.sv

// ==== verilog/backEndTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module backEndTop (
    input  wire logic        clk,
    input  wire logic        rst1,
    input  wire logic        stall,
    input  wire logic        flush1,
    input  wire logic        flush2,
    input  wire logic        regWrite1,
    input  wire logic [1:0]  resultSrc1,
    input  wire logic        memWrite1,
    input  wire logic [2:0]  addrCtl1,
    input  wire logic [31:0] aluResult1,
    input  wire logic [31:0] writeData1,
    input  wire logic [4:0]  rd1,
    input  wire logic [31:0] pcPlus4_1,
    input  wire logic [31:0] pcPlus8_1,
    input  wire logic        regWrite2,
    input  wire logic [1:0]  resultSrc2,
    input  wire logic        memWrite2,
    input  wire logic [2:0]  addrCtl2,
    input  wire logic [31:0] aluResult2,
    input  wire logic [31:0] writeData2,
    input  wire logic [4:0]  rd2,
    input  wire logic [31:0] pcPlus4_2,
    input  wire logic [31:0] pcPlus8_2,
    input  wire logic [4:0]  readAddr1,
    input  wire logic [4:0]  readAddr2,
    output logic [31:0]      readData1,
    output logic [31:0]      readData2,
    output logic             wbWrite1,
    output logic             wbWrite2,
    output logic [4:0]       wbRd1,
    output logic [4:0]       wbRd2,
    output logic [31:0]      wbResult1,
    output logic [31:0]      wbResult2
);

    laneIf exLane1 ();
    laneIf exLane2 ();
    laneIf memLane1 ();
    laneIf memLane2 ();
    pipeCtlIf pipeCtl ();

    logic              wbClear;
    logic              storeGate;
    backEndPkg::word_t loadData1;
    backEndPkg::word_t loadData2;

    assign exLane1.regWrite  = regWrite1;
    assign exLane1.resultSrc = backEndPkg::resultSrc_e'(resultSrc1);
    assign exLane1.memWrite  = memWrite1;
    assign exLane1.addrCtl   = addrCtl1;
    assign exLane1.aluResult = aluResult1;
    assign exLane1.writeData = writeData1;
    assign exLane1.rd        = rd1;
    assign exLane1.pcPlus4   = pcPlus4_1;
    assign exLane1.pcPlus8   = pcPlus8_1;

    assign exLane2.regWrite  = regWrite2;
    assign exLane2.resultSrc = backEndPkg::resultSrc_e'(resultSrc2);
    assign exLane2.memWrite  = memWrite2;
    assign exLane2.addrCtl   = addrCtl2;
    assign exLane2.aluResult = aluResult2;
    assign exLane2.writeData = writeData2;
    assign exLane2.rd        = rd2;
    assign exLane2.pcPlus4   = pcPlus4_2;
    assign exLane2.pcPlus8   = pcPlus8_2;

    pipeControl control (
        .clk(clk), .rst1(rst1), .stall(stall), .flush1(flush1), .flush2(flush2),
        .ctl(pipeCtl.ctl), .wbClear(wbClear), .storeGate(storeGate)
    );

    executeToMemoryRegister exMem (
        .clk(clk), .rst1(rst1), .ctl(pipeCtl.stage),
        .inLane1(exLane1.sink), .inLane2(exLane2.sink),
        .outLane1(memLane1.source), .outLane2(memLane2.source)
    );

    dataMemory dmem (
        .clk(clk), .storeGate(storeGate),
        .lane1(memLane1.sink), .lane2(memLane2.sink),
        .loadData1(loadData1), .loadData2(loadData2)
    );

    writebackStage writeback (
        .clk(clk), .rst1(rst1), .wbClear(wbClear),
        .lane1(memLane1.sink), .lane2(memLane2.sink),
        .loadData1(loadData1), .loadData2(loadData2),
        .readAddr1(readAddr1), .readAddr2(readAddr2),
        .readData1(readData1), .readData2(readData2),
        .wbWrite1(wbWrite1), .wbWrite2(wbWrite2),
        .wbRd1(wbRd1), .wbRd2(wbRd2),
        .wbResult1(wbResult1), .wbResult2(wbResult2)
    );

endmodule

`default_nettype wire

// ==== verilog/executeToMemoryRegister.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeToMemoryRegister (
    input  wire logic clk,
    input  wire logic rst1,
    pipeCtlIf.stage   ctl,
    laneIf.sink       inLane1,
    laneIf.sink       inLane2,
    laneIf.source     outLane1,
    laneIf.source     outLane2
);

    // Lane 1, the older instruction.
    always_ff @(posedge clk) begin
        if (rst1 || ctl.clear1) begin
            outLane1.regWrite  <= 1'b0;
            outLane1.resultSrc <= backEndPkg::resAlu;
            outLane1.memWrite  <= 1'b0;
            outLane1.addrCtl   <= '0;
            outLane1.aluResult <= '0;
            outLane1.writeData <= '0;
            outLane1.rd        <= '0;
            outLane1.pcPlus4   <= '0;
            outLane1.pcPlus8   <= '0;
        end else if (ctl.en1) begin
            outLane1.regWrite  <= inLane1.regWrite;
            outLane1.resultSrc <= inLane1.resultSrc;
            outLane1.memWrite  <= inLane1.memWrite;
            outLane1.addrCtl   <= inLane1.addrCtl;
            outLane1.aluResult <= inLane1.aluResult;
            outLane1.writeData <= inLane1.writeData;
            outLane1.rd        <= inLane1.rd;
            outLane1.pcPlus4   <= inLane1.pcPlus4;
            outLane1.pcPlus8   <= inLane1.pcPlus8;
        end
    end

    // Lane 2, the younger instruction.
    always_ff @(posedge clk) begin
        if (rst1 || ctl.clear2) begin
            outLane2.regWrite  <= 1'b0;
            outLane2.resultSrc <= backEndPkg::resAlu;
            outLane2.memWrite  <= 1'b0;
            outLane2.addrCtl   <= '0;
            outLane2.aluResult <= '0;
            outLane2.writeData <= '0;
            outLane2.rd        <= '0;
            outLane2.pcPlus4   <= '0;
            outLane2.pcPlus8   <= '0;
        end else if (ctl.en2) begin
            outLane2.regWrite  <= inLane2.regWrite;
            outLane2.resultSrc <= inLane2.resultSrc;
            outLane2.memWrite  <= inLane2.memWrite;
            outLane2.addrCtl   <= inLane2.addrCtl;
            outLane2.aluResult <= inLane2.aluResult;
            outLane2.writeData <= inLane2.writeData;
            outLane2.rd        <= inLane2.rd;
            outLane2.pcPlus4   <= inLane2.pcPlus4;
            outLane2.pcPlus8   <= inLane2.pcPlus8;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipeControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeControl (
    input  wire logic clk,
    input  wire logic rst1,
    input  wire logic stall,
    input  wire logic flush1,
    input  wire logic flush2,
    pipeCtlIf.ctl     ctl,
    output logic      wbClear,
    output logic      storeGate
);

    backEndPkg::ctlState_e state;

    // The pair in the memory stage is a repeat for every cycle after a stalled edge.
    always_ff @(posedge clk) begin
        if (rst1) begin
            state <= backEndPkg::ctlRun;
        end else if (stall) begin
            state <= backEndPkg::ctlHold;
        end else begin
            state <= backEndPkg::ctlRun;
        end
    end

    assign wbClear   = (state == backEndPkg::ctlHold);
    assign storeGate = (state != backEndPkg::ctlHold);

    // A flush takes effect even while stalled.
    assign ctl.clear1 = flush1;
    assign ctl.clear2 = flush2;
    assign ctl.en1    = !stall && !flush1;
    assign ctl.en2    = !stall && !flush2;

    enClearExclusive: assert property (
        @(posedge clk) disable iff (rst1)
        !(ctl.en1 && ctl.clear1) && !(ctl.en2 && ctl.clear2)
    ) else $error("Lane enable and clear both high.");

endmodule

`default_nettype wire

// ==== verilog/writebackStage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "backEnd_config.svh"

module writebackStage (
    input  wire logic                 clk,
    input  wire logic                 rst1,
    input  wire logic                 wbClear,
    laneIf.sink                       lane1,
    laneIf.sink                       lane2,
    input  wire backEndPkg::word_t    loadData1,
    input  wire backEndPkg::word_t    loadData2,
    input  wire backEndPkg::regAddr_t readAddr1,
    input  wire backEndPkg::regAddr_t readAddr2,
    output backEndPkg::word_t         readData1,
    output backEndPkg::word_t         readData2,
    output logic                      wbWrite1,
    output logic                      wbWrite2,
    output backEndPkg::regAddr_t      wbRd1,
    output backEndPkg::regAddr_t      wbRd2,
    output backEndPkg::word_t         wbResult1,
    output backEndPkg::word_t         wbResult2
);

    backEndPkg::resultSrc_e srcQ1, srcQ2;
    backEndPkg::word_t      aluQ1, aluQ2;
    backEndPkg::word_t      loadQ1, loadQ2;
    backEndPkg::word_t      pc4Q1, pc4Q2;
    backEndPkg::word_t      pc8Q1, pc8Q2;

    backEndPkg::word_t regs [`BE_NUM_REGS];

    function automatic backEndPkg::word_t selectResult(input backEndPkg::resultSrc_e src,
                                                       input backEndPkg::word_t alu,
                                                       input backEndPkg::word_t load,
                                                       input backEndPkg::word_t pc4,
                                                       input backEndPkg::word_t pc8);
        case (src)
            backEndPkg::resMem: return load;
            backEndPkg::resPc4: return pc4;
            backEndPkg::resPc8: return pc8;
            default:            return alu;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst1 || wbClear) begin
            wbWrite1 <= 1'b0;
            wbWrite2 <= 1'b0;
            wbRd1    <= '0;
            wbRd2    <= '0;
            srcQ1    <= backEndPkg::resAlu;
            srcQ2    <= backEndPkg::resAlu;
        end else begin
            wbWrite1 <= lane1.regWrite;
            wbWrite2 <= lane2.regWrite;
            wbRd1    <= lane1.rd;
            wbRd2    <= lane2.rd;
            srcQ1    <= lane1.resultSrc;
            srcQ2    <= lane2.resultSrc;
        end
    end

    always_ff @(posedge clk) begin
        aluQ1  <= lane1.aluResult;
        aluQ2  <= lane2.aluResult;
        loadQ1 <= loadData1;
        loadQ2 <= loadData2;
        pc4Q1  <= lane1.pcPlus4;
        pc4Q2  <= lane2.pcPlus4;
        pc8Q1  <= lane1.pcPlus8;
        pc8Q2  <= lane2.pcPlus8;
    end

    assign wbResult1 = selectResult(srcQ1, aluQ1, loadQ1, pc4Q1, pc8Q1);
    assign wbResult2 = selectResult(srcQ2, aluQ2, loadQ2, pc4Q2, pc8Q2);

    always_ff @(posedge clk) begin
        if (rst1) begin
            regs[0] <= '0;
        end else begin
            if (wbWrite1 && (wbRd1 != '0)) regs[wbRd1] <= wbResult1;
            if (wbWrite2 && (wbRd2 != '0)) regs[wbRd2] <= wbResult2; // Younger lane wins.
        end
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

    x0ReadsZero: assert property (
        @(posedge clk) disable iff (rst1)
        ((readAddr1 == '0) |-> (readData1 == '0)) and ((readAddr2 == '0) |-> (readData2 == '0))
    ) else $error("Register x0 read nonzero.");

endmodule

`default_nettype wire
